//--- logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

  typedef logic [5:0] op_t;
  typedef logic [5:0] funct_t;

  // primary opcodes, instr[31:26]
  localparam op_t op_special = 6'h00;
  localparam op_t op_regimm  = 6'h01;
  localparam op_t op_j       = 6'h02;
  localparam op_t op_jal     = 6'h03;
  localparam op_t op_beq     = 6'h04;
  localparam op_t op_bne     = 6'h05;
  localparam op_t op_blez    = 6'h06;
  localparam op_t op_bgtz    = 6'h07;
  localparam op_t op_addi    = 6'h08;
  localparam op_t op_addiu   = 6'h09;
  localparam op_t op_ori     = 6'h0d;
  localparam op_t op_lui     = 6'h0f;
  localparam op_t op_lw      = 6'h23;
  localparam op_t op_sw      = 6'h2b;

  // SPECIAL function codes, instr[5:0]
  localparam funct_t fn_jr   = 6'h08;
  localparam funct_t fn_add  = 6'h20;
  localparam funct_t fn_addu = 6'h21;
  localparam funct_t fn_sub  = 6'h22;
  localparam funct_t fn_and  = 6'h24;
  localparam funct_t fn_or   = 6'h25;
  localparam funct_t fn_slt  = 6'h2a;

  // REGIMM branch select in the rt field
  localparam logic [4:0] rt_bltz = 5'h00;
  localparam logic [4:0] rt_bgez = 5'h01;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_lui,
    alu_undef
  } alu_op_t;

  typedef enum logic [3:0] {
    bcu_none,
    bcu_eq,
    bcu_ne,
    bcu_lez,
    bcu_gtz,
    bcu_ltz,
    bcu_gez
  } bcu_op_t;

  typedef enum logic [1:0] {
    jmp_none,
    jmp_target,
    jmp_reg
  } jump_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_to_reg;
    logic    mem_write;
    logic    alu_src;
    logic    reg_dst;
    logic    jal;
    logic    illegal;
    logic    zero_ext;
    jump_t   jump;
    alu_op_t alu_op;
    bcu_op_t bcu_op;
  } ctrl_t;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dmem_req_t;

  localparam logic [31:0] reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  mips_pkg::alu_op_t op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  output logic [31:0]       result
);

  logic [31:0] sum;
  logic [31:0] diff;
  logic        lt;

  assign sum  = a + b;
  assign diff = a - b;

  // signed compare for slt
  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      mips_pkg::alu_add: begin
        result = sum;
      end
      mips_pkg::alu_sub: begin
        result = diff;
      end
      mips_pkg::alu_and: begin
        result = a & b;
      end
      mips_pkg::alu_or: begin
        result = a | b;
      end
      mips_pkg::alu_slt: begin
        result = {31'b0, lt};
      end
      // immediate into the upper half
      mips_pkg::alu_lui: begin
        result = {b[15:0], 16'h0000};
      end
      default: begin
        result = 32'h0000_0000;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  mips_pkg::bcu_op_t op,
  input  logic [31:0]       rs_val,
  input  logic [31:0]       rt_val,
  output logic              taken
);

  logic eq;
  logic neg;
  logic zero;

  assign eq   = (rs_val == rt_val);
  assign neg  = rs_val[31];
  assign zero = (rs_val == 32'h0000_0000);

  // zero tests are signed on rs only
  always_comb begin
    case (op)
      mips_pkg::bcu_eq: taken = eq;
      mips_pkg::bcu_ne: taken = !eq;
      mips_pkg::bcu_lez: taken = neg || zero;
      mips_pkg::bcu_gtz: taken = !neg && !zero;
      mips_pkg::bcu_ltz: taken = neg;
      mips_pkg::bcu_gez: taken = !neg;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic [31:0]     instr,
  output mips_pkg::ctrl_t ctrl
);

  mips_pkg::op_t    op;
  mips_pkg::funct_t fn;
  logic [4:0]       rt;
  logic             legal;

  assign op = instr[31:26];
  assign fn = instr[5:0];
  assign rt = instr[20:16];

  // anything outside the supported subset
  always_comb begin
    case (op)
      mips_pkg::op_special: begin
        case (fn)
          mips_pkg::fn_jr, mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub,
          mips_pkg::fn_and, mips_pkg::fn_or, mips_pkg::fn_slt: legal = 1'b1;
          default: legal = 1'b0;
        endcase
      end
      mips_pkg::op_regimm: legal = (rt == mips_pkg::rt_bltz) || (rt == mips_pkg::rt_bgez);
      mips_pkg::op_j, mips_pkg::op_jal, mips_pkg::op_beq, mips_pkg::op_bne,
      mips_pkg::op_blez, mips_pkg::op_bgtz, mips_pkg::op_addi, mips_pkg::op_addiu,
      mips_pkg::op_ori, mips_pkg::op_lui, mips_pkg::op_lw, mips_pkg::op_sw: legal = 1'b1;
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    ctrl.illegal = !legal;

    // writes are suppressed for illegal words
    case (op)
      mips_pkg::op_special: ctrl.reg_write = legal && (fn != mips_pkg::fn_jr);
      mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_ori, mips_pkg::op_lui,
      mips_pkg::op_lw, mips_pkg::op_jal: ctrl.reg_write = 1'b1;
      default: ctrl.reg_write = 1'b0;
    endcase

    case (op)
      mips_pkg::op_sw: ctrl.mem_write = 1'b1;
      default: ctrl.mem_write = 1'b0;
    endcase

    case (op)
      mips_pkg::op_lw: ctrl.mem_to_reg = 1'b1;
      default: ctrl.mem_to_reg = 1'b0;
    endcase

    case (op)
      mips_pkg::op_j, mips_pkg::op_jal: ctrl.jump = mips_pkg::jmp_target;
      mips_pkg::op_special:
        ctrl.jump = (fn == mips_pkg::fn_jr) ? mips_pkg::jmp_reg : mips_pkg::jmp_none;
      default: ctrl.jump = mips_pkg::jmp_none;
    endcase

    case (op)
      mips_pkg::op_jal: ctrl.jal = 1'b1;
      default: ctrl.jal = 1'b0;
    endcase

    case (op)
      mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_ori, mips_pkg::op_lui,
      mips_pkg::op_lw, mips_pkg::op_sw: ctrl.alu_src = 1'b1;
      default: ctrl.alu_src = 1'b0;
    endcase

    case (op)
      mips_pkg::op_ori: ctrl.zero_ext = 1'b1;
      default: ctrl.zero_ext = 1'b0;
    endcase

    case (op)
      mips_pkg::op_special: ctrl.reg_dst = 1'b1;
      default: ctrl.reg_dst = 1'b0;
    endcase

    case (op)
      mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_lw, mips_pkg::op_sw:
        ctrl.alu_op = mips_pkg::alu_add;
      mips_pkg::op_ori: ctrl.alu_op = mips_pkg::alu_or;
      mips_pkg::op_lui: ctrl.alu_op = mips_pkg::alu_lui;
      // r-type
      mips_pkg::op_special: begin
        case (fn)
          mips_pkg::fn_add, mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
          mips_pkg::fn_sub: ctrl.alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and: ctrl.alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or: ctrl.alu_op = mips_pkg::alu_or;
          mips_pkg::fn_slt: ctrl.alu_op = mips_pkg::alu_slt;
          default: ctrl.alu_op = mips_pkg::alu_undef;
        endcase
      end
      default: ctrl.alu_op = mips_pkg::alu_undef;
    endcase

    case (op)
      mips_pkg::op_beq: ctrl.bcu_op = mips_pkg::bcu_eq;
      mips_pkg::op_bne: ctrl.bcu_op = mips_pkg::bcu_ne;
      mips_pkg::op_blez: ctrl.bcu_op = mips_pkg::bcu_lez;
      mips_pkg::op_bgtz: ctrl.bcu_op = mips_pkg::bcu_gtz;
      mips_pkg::op_regimm: begin
        case (rt)
          mips_pkg::rt_bltz: ctrl.bcu_op = mips_pkg::bcu_ltz;
          mips_pkg::rt_bgez: ctrl.bcu_op = mips_pkg::bcu_gez;
          default: ctrl.bcu_op = mips_pkg::bcu_none;
        endcase
      end
      default: ctrl.bcu_op = mips_pkg::bcu_none;
    endcase
  end

  a_no_write_on_illegal: assert final (!(ctrl.illegal && (ctrl.reg_write || ctrl.mem_write)));

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  ra,
  input  logic [4:0]  rb,
  output logic [31:0] rd_a,
  output logic [31:0] rd_b,
  input  logic        we,
  input  logic [4:0]  wa,
  input  logic [31:0] wd
);

  // r0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'h0000_0000;
      end
    end else if (we && (wa != 5'd0)) begin
      regs[wa] <= wd;
    end
  end

  assign rd_a = (ra == 5'd0) ? 32'h0000_0000 : regs[ra];
  assign rd_b = (rb == 5'd0) ? 32'h0000_0000 : regs[rb];

  a_wa_known: assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(wa));

endmodule

`default_nettype wire

//--- logic/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic                clk,
  input  logic                rst,
  output logic [31:0]         imem_addr,
  input  logic [31:0]         imem_data,
  output mips_pkg::dmem_req_t dmem,
  input  logic [31:0]         dmem_rdata,
  output logic                illegal_instr
);

  mips_pkg::ctrl_t ctrl;

  logic [31:0] pc;
  logic [31:0] pc_next;
  logic [31:0] pc_plus4;
  logic [31:0] br_target;
  logic [31:0] jmp_addr;

  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [15:0] imm;
  logic [31:0] imm_ext;

  logic [31:0] rs_val;
  logic [31:0] rt_val;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        taken;

  logic [4:0]  wb_addr;
  logic [31:0] wb_data;

  assign rs  = imem_data[25:21];
  assign rt  = imem_data[20:16];
  assign rd  = imem_data[15:11];
  assign imm = imem_data[15:0];

  control_unit u_ctrl (
    .instr (imem_data),
    .ctrl  (ctrl)
  );

  reg_file u_regs (
    .clk  (clk),
    .rst  (rst),
    .ra   (rs),
    .rb   (rt),
    .rd_a (rs_val),
    .rd_b (rt_val),
    .we   (ctrl.reg_write),
    .wa   (wb_addr),
    .wd   (wb_data)
  );

  // ori zero extends, everything else sign extends
  assign imm_ext = ctrl.zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign alu_b   = ctrl.alu_src ? imm_ext : rt_val;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs_val),
    .b      (alu_b),
    .result (alu_result)
  );

  branch_unit u_bcu (
    .op     (ctrl.bcu_op),
    .rs_val (rs_val),
    .rt_val (rt_val),
    .taken  (taken)
  );

  assign pc_plus4  = pc + 32'd4;
  assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
  assign jmp_addr  = {pc_plus4[31:28], imem_data[25:0], 2'b00};

  always_comb begin
    if (ctrl.illegal) begin
      // stall on the bad word
      pc_next = pc;
    end else begin
      case (ctrl.jump)
        mips_pkg::jmp_target: pc_next = jmp_addr;
        mips_pkg::jmp_reg: pc_next = rs_val;
        default: pc_next = taken ? br_target : pc_plus4;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= mips_pkg::reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  assign imem_addr = pc;

  // write-back select, jal links into r31
  assign wb_addr = ctrl.jal ? 5'd31 : (ctrl.reg_dst ? rd : rt);

  always_comb begin
    if (ctrl.jal) begin
      wb_data = pc_plus4;
    end else if (ctrl.mem_to_reg) begin
      wb_data = dmem_rdata;
    end else begin
      wb_data = alu_result;
    end
  end

  assign dmem = '{
    we:    ctrl.mem_write && !rst,
    addr:  alu_result,
    wdata: rt_val
  };

  assign illegal_instr = ctrl.illegal && !rst;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- sim/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

  localparam int max_cycles = 400;

  logic                clk;
  logic                rst;
  logic [31:0]         imem_addr;
  logic [31:0]         imem_data;
  mips_pkg::dmem_req_t dmem;
  logic [31:0]         dmem_rdata;
  logic                illegal_instr;

  logic [31:0] imem [0:255];
  logic [31:0] dmem_mem [0:255];

  // reference model state
  logic [31:0] m_pc;
  logic [31:0] m_regs [0:31];
  logic [31:0] m_dmem [0:255];
  logic        m_illegal;

  integer seed;
  int     errors;
  int     wp;

  cpu_core dut0 (
    .clk           (clk),
    .rst           (rst),
    .imem_addr     (imem_addr),
    .imem_data     (imem_data),
    .dmem          (dmem),
    .dmem_rdata    (dmem_rdata),
    .illegal_instr (illegal_instr)
  );

  always #20 clk = ~clk;

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem_mem[dmem.addr[9:2]];

  always @(posedge clk) begin
    if (dmem.we) begin
      dmem_mem[dmem.addr[9:2]] <= dmem.wdata;
    end
  end

  function automatic logic [31:0] rtype(mips_pkg::funct_t fn, int rs, int rt, int rd);
    return {mips_pkg::op_special, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic logic [31:0] itype(mips_pkg::op_t op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] jtype(mips_pkg::op_t op, int idx);
    return {op, idx[25:0]};
  endfunction

  // steps the model by one instruction and returns the expected data memory request
  function automatic mips_pkg::dmem_req_t exec_step(input logic [31:0] instr);
    mips_pkg::dmem_req_t req;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] pc4;
    logic [31:0] nxt;
    logic [31:0] addr;
    logic [4:0]  wa;
    logic [31:0] wd;
    logic        wen;
    logic        br;
    logic        bad;
    req  = '0;
    a    = m_regs[instr[25:21]];
    b    = m_regs[instr[20:16]];
    se   = {{16{instr[15]}}, instr[15:0]};
    pc4  = m_pc + 32'd4;
    nxt  = pc4;
    addr = a + se;
    wa   = instr[20:16];
    wd   = 32'h0000_0000;
    wen  = 1'b1;
    br   = 1'b0;
    bad  = 1'b0;
    case (instr[31:26])
      mips_pkg::op_special: begin
        wa = instr[15:11];
        case (instr[5:0])
          mips_pkg::fn_jr: begin
            wen = 1'b0;
            nxt = a;
          end
          mips_pkg::fn_add, mips_pkg::fn_addu: wd = a + b;
          mips_pkg::fn_sub: wd = a - b;
          mips_pkg::fn_and: wd = a & b;
          mips_pkg::fn_or: wd = a | b;
          mips_pkg::fn_slt: wd = {31'b0, $signed(a) < $signed(b)};
          default: bad = 1'b1;
        endcase
      end
      mips_pkg::op_regimm: begin
        wen = 1'b0;
        if (instr[20:16] == mips_pkg::rt_bltz) begin
          br = $signed(a) < 0;
        end else if (instr[20:16] == mips_pkg::rt_bgez) begin
          br = $signed(a) >= 0;
        end else begin
          bad = 1'b1;
        end
      end
      mips_pkg::op_j, mips_pkg::op_jal: begin
        wen = (instr[31:26] == mips_pkg::op_jal);
        wa  = 5'd31;
        wd  = pc4;
        nxt = {pc4[31:28], instr[25:0], 2'b00};
      end
      mips_pkg::op_beq: {wen, br} = {1'b0, a == b};
      mips_pkg::op_bne: {wen, br} = {1'b0, a != b};
      mips_pkg::op_blez: {wen, br} = {1'b0, $signed(a) <= 0};
      mips_pkg::op_bgtz: {wen, br} = {1'b0, $signed(a) > 0};
      mips_pkg::op_addi, mips_pkg::op_addiu: wd = addr;
      mips_pkg::op_ori: wd = a | {16'h0000, instr[15:0]};
      mips_pkg::op_lui: wd = {instr[15:0], 16'h0000};
      mips_pkg::op_lw: wd = m_dmem[addr[9:2]];
      mips_pkg::op_sw: begin
        wen       = 1'b0;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = b;
      end
      default: bad = 1'b1;
    endcase
    if (br) begin
      nxt = pc4 + {se[29:0], 2'b00};
    end
    // an illegal word commits nothing and holds the pc
    if (bad) begin
      m_illegal = 1'b1;
      req = '0;
    end else begin
      if (wen && wa != 5'd0) begin
        m_regs[wa] = wd;
      end
      if (req.we) begin
        m_dmem[req.addr[9:2]] = req.wdata;
      end
      m_pc = nxt;
    end
    return req;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    errors++;
    $display("FAIL %s: expected %h, actual %h", name, want, got);
  endtask

  task automatic emit(input logic [31:0] w);
    imem[wp[7:0]] = w;
    wp++;
  endtask

  task automatic branch_over(input logic [31:0] w);
    emit(w);
    emit(itype(mips_pkg::op_addiu, 18, 18, 1));
  endtask

  task automatic load_program();
    int i;
    int n;
    for (i = 0; i < 256; i++) begin
      // unused words decode as illegal
      imem[i[7:0]] = {6'h3f, 26'(i)};
      dmem_mem[i[7:0]] = $random(seed);
    end
    wp = 0;
    // alu ops with results stored to words 1..11
    emit(itype(mips_pkg::op_addiu, 0, 1, $random(seed)));
    emit(itype(mips_pkg::op_addi, 0, 2, $random(seed) | 32'h8000));
    emit(itype(mips_pkg::op_ori, 1, 3, $random(seed)));
    emit(itype(mips_pkg::op_lui, 0, 4, $random(seed)));
    emit(rtype(mips_pkg::fn_add, 1, 2, 5));
    emit(rtype(mips_pkg::fn_addu, 3, 4, 6));
    emit(rtype(mips_pkg::fn_sub, 1, 2, 7));
    emit(rtype(mips_pkg::fn_and, 3, 2, 8));
    emit(rtype(mips_pkg::fn_or, 4, 1, 9));
    emit(rtype(mips_pkg::fn_slt, 2, 1, 10));
    emit(rtype(mips_pkg::fn_slt, 1, 2, 11));
    for (i = 1; i < 12; i++) begin
      emit(itype(mips_pkg::op_sw, 0, i, i * 4));
    end
    for (i = 0; i < 4; i++) begin
      emit(itype(mips_pkg::op_lw, 0, 12, (128 + i) * 4));
      emit(itype(mips_pkg::op_sw, 0, 12, (160 + i) * 4));
    end
    // r0 must ignore both writes
    emit(itype(mips_pkg::op_addiu, 0, 0, $random(seed)));
    emit(rtype(mips_pkg::fn_addu, 1, 1, 0));
    emit(itype(mips_pkg::op_sw, 0, 0, 200 * 4));
    emit(itype(mips_pkg::op_addiu, 0, 13, -1));
    emit(itype(mips_pkg::op_addiu, 0, 15, 1));
    emit(itype(mips_pkg::op_lui, 0, 16, 32'h8000));
    emit(itype(mips_pkg::op_lui, 0, 17, 32'h7fff));
    emit(itype(mips_pkg::op_ori, 17, 17, 32'hffff));
    branch_over(itype(mips_pkg::op_beq, 15, 15, 1));
    branch_over(itype(mips_pkg::op_beq, 15, 13, 1));
    branch_over(itype(mips_pkg::op_bne, 13, 15, 1));
    branch_over(itype(mips_pkg::op_bne, 16, 16, 1));
    branch_over(itype(mips_pkg::op_blez, 0, 0, 1));
    branch_over(itype(mips_pkg::op_blez, 15, 0, 1));
    branch_over(itype(mips_pkg::op_blez, 16, 0, 1));
    branch_over(itype(mips_pkg::op_bgtz, 17, 0, 1));
    branch_over(itype(mips_pkg::op_bgtz, 0, 0, 1));
    branch_over(itype(mips_pkg::op_regimm, 16, int'(mips_pkg::rt_bltz), 1));
    branch_over(itype(mips_pkg::op_regimm, 0, int'(mips_pkg::rt_bltz), 1));
    branch_over(itype(mips_pkg::op_regimm, 0, int'(mips_pkg::rt_bgez), 1));
    branch_over(itype(mips_pkg::op_regimm, 13, int'(mips_pkg::rt_bgez), 1));
    // three passes through a backward branch
    emit(itype(mips_pkg::op_addiu, 0, 19, 3));
    emit(itype(mips_pkg::op_addiu, 19, 19, -1));
    emit(itype(mips_pkg::op_bne, 19, 0, -2));
    emit(itype(mips_pkg::op_sw, 0, 18, 204 * 4));
    emit(itype(mips_pkg::op_sw, 0, 19, 205 * 4));
    n = wp;
    emit(jtype(mips_pkg::op_jal, n + 3));
    emit(itype(mips_pkg::op_sw, 0, 31, 210 * 4));
    emit(jtype(mips_pkg::op_j, n + 5));
    emit(itype(mips_pkg::op_addiu, 20, 20, 5));
    emit(rtype(mips_pkg::fn_jr, 31, 0, 0));
    emit(itype(mips_pkg::op_sw, 0, 20, 211 * 4));
    // SPECIAL with an unsupported function code ends the program
    emit(32'h0000_003f);
  endtask

  initial begin
    mips_pkg::dmem_req_t want;
    int          i;
    int          cycles;
    logic        done;
    logic [31:0] first_word;
    clk    = 1'b0;
    rst    = 1'b1;
    seed   = 32'h23f8_71c2;
    errors = 0;
    load_program();
    for (i = 0; i < 256; i++) begin
      m_dmem[i[7:0]] = dmem_mem[i[7:0]];
    end
    for (i = 0; i < 32; i++) begin
      m_regs[i[4:0]] = 32'h0000_0000;
    end
    m_pc      = mips_pkg::reset_pc;
    m_illegal = 1'b0;

    // a store and then an illegal word sit at the reset pc while rst is high
    first_word = imem[m_pc[9:2]];
    imem[m_pc[9:2]] = itype(mips_pkg::op_sw, 0, 0, 0);
    @(negedge clk);
    assert (imem_addr == mips_pkg::reset_pc)
      else report_mismatch("reset pc", mips_pkg::reset_pc, imem_addr);
    assert (!dmem.we) else report_mismatch("reset dmem we", 32'd0, {31'b0, dmem.we});
    imem[m_pc[9:2]] = 32'h0000_003f;
    @(negedge clk);
    assert (imem_addr == mips_pkg::reset_pc)
      else report_mismatch("reset pc", mips_pkg::reset_pc, imem_addr);
    assert (!illegal_instr)
      else report_mismatch("reset illegal_instr", 32'd0, {31'b0, illegal_instr});
    imem[m_pc[9:2]] = first_word;
    rst = 1'b0;
    // the core runs the first word during this cycle
    want = exec_step(imem[m_pc[9:2]]);

    cycles = 0;
    done   = m_illegal;
    while (!done && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
      assert (imem_addr == m_pc) else report_mismatch("pc", m_pc, imem_addr);
      want = exec_step(imem[m_pc[9:2]]);
      assert (illegal_instr == m_illegal)
        else report_mismatch("illegal_instr", {31'b0, m_illegal}, {31'b0, illegal_instr});
      assert (dmem.we == want.we)
        else report_mismatch("dmem we", {31'b0, want.we}, {31'b0, dmem.we});
      if (want.we) begin
        assert (dmem.addr == want.addr) else report_mismatch("dmem addr", want.addr, dmem.addr);
        assert (dmem.wdata == want.wdata)
          else report_mismatch("dmem wdata", want.wdata, dmem.wdata);
      end
      done = m_illegal;
    end

    if (!done) begin
      errors++;
      $display("timeout: illegal_instr did not rise within %0d cycles", max_cycles);
    end else begin
      // core must sit on the bad word
      for (i = 0; i < 5; i++) begin
        @(negedge clk);
        assert (imem_addr == m_pc) else report_mismatch("halt pc", m_pc, imem_addr);
        assert (!dmem.we) else report_mismatch("halt dmem we", 32'd0, {31'b0, dmem.we});
        assert (illegal_instr)
          else report_mismatch("halt illegal_instr", 32'd1, {31'b0, illegal_instr});
      end
    end

    $display("run finished after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
logic/mips_pkg.sv
logic/alu.sv
logic/branch_unit.sv
logic/control_unit.sv
logic/reg_file.sv
logic/cpu_core.sv
sim/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_cpu
BUILD     ?= obj_dir
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell cat list.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f list.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
